// File: logic/sdramPkg.sv
/* Widths, SDRAM timing, command codes and the shared structs
   for the frame-buffer controller */
`default_nettype none

package sdramPkg;

    // ====================
    // Widths
    // ====================
    localparam int DATA_W     = 16;
    localparam int COL_W      = 8;
    localparam int ROW_W      = 12;
    localparam int BANK_W     = 2;
    localparam int ADDR_W     = COL_W + ROW_W + BANK_W;  // 22-bit word address
    localparam int LEN_W      = 8;
    localparam int FIFO_DEPTH = 512;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int CNT_W      = 10;                      // Holds 0..FIFO_DEPTH

    // ====================
    // Timing in CLK cycles
    // ====================
    localparam int CAS_LAT    = 2;
    localparam int T_RCD      = 2;
    localparam int T_RP       = 2;
    localparam int T_RFC      = 7;
    localparam int REF_PERIOD = 390;
    localparam int INIT_WAIT  = 200;                     // Short power-up wait for sim
    localparam int WAIT_W     = $clog2(INIT_WAIT + 1);
    localparam int REF_W      = $clog2(REF_PERIOD);

    // Command codes in {rasN, casN, weN} bit order
    localparam logic [2:0] CMD_NOP       = 3'b111;
    localparam logic [2:0] CMD_ACTIVE    = 3'b011;
    localparam logic [2:0] CMD_READ      = 3'b101;
    localparam logic [2:0] CMD_WRITE     = 3'b100;
    localparam logic [2:0] CMD_BSTOP     = 3'b110;
    localparam logic [2:0] CMD_PRECHARGE = 3'b010;
    localparam logic [2:0] CMD_REFRESH   = 3'b001;
    localparam logic [2:0] CMD_MODE      = 3'b000;

    // Burst write, normal op, CAS 2, sequential, full page
    localparam logic [ROW_W-1:0] MODE_WORD = {2'b00, 1'b0, 2'b00, 3'(CAS_LAT), 1'b0, 3'b111};
    localparam logic [ROW_W-1:0] PRE_ALL   = ROW_W'(1 << 10);  // A10 selects all banks

    typedef struct packed {
        logic                cke;
        logic                csN;
        logic                rasN;
        logic                casN;
        logic                weN;
        logic [BANK_W-1:0]   ba;
        logic [ROW_W-1:0]    addr;
        logic [DATA_W/8-1:0] dqm;
    } sdramBus;

    typedef struct packed {
        logic [ADDR_W-1:0] startAddr;
        logic [ADDR_W-1:0] maxAddr;
        logic [LEN_W-1:0]  length;
    } portConfig;

    typedef struct packed {
        logic              isWrite;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  length;
    } burstReq;

endpackage

`default_nettype wire

// File: logic/sdramFifo.sv
/* Synchronous word FIFO with clear and used-word count */
`timescale 1ns/1ps
`default_nettype none

module sdramFifo
    import sdramPkg::*;
(
    input  wire logic              CLK,
    input  wire logic              RESET_N,
    input  wire logic              clear,     // Empties in one cycle
    input  wire logic              push,
    input  wire logic [DATA_W-1:0] pushData,
    input  wire logic              pop,
    output logic [DATA_W-1:0]      popData,
    output logic [CNT_W-1:0]       used
);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wrPtr;
    logic [PTR_W-1:0]  rdPtr;
    logic              doPush;
    logic              doPop;

    // Full drops the push, empty keeps the last word
    assign doPush = push && (used != CNT_W'(FIFO_DEPTH));
    assign doPop  = pop && (used != '0);

    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            used  <= '0;
        end
        else if (clear)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            used  <= '0;
        end
        else
        begin
            if (doPush)
                wrPtr <= wrPtr + 1'b1;
            if (doPop)
                rdPtr <= rdPtr + 1'b1;
            used <= used + CNT_W'(doPush) - CNT_W'(doPop);
        end
    end

    // RAM and registered head
    always_ff @(posedge CLK)
    begin
        if (doPush && !clear)
            mem[wrPtr] <= pushData;
        if (doPop)
            popData <= mem[rdPtr];  // Valid the cycle after pop
    end

endmodule

`default_nettype wire

// File: logic/portArbiter.sv
/* Address windows of the write and read ports, write-first burst choice
   and the burst request held until burstDone */
`timescale 1ns/1ps
`default_nettype none

module portArbiter
    import sdramPkg::*;
(
    input  wire logic             CLK,
    input  wire logic             RESET_N,
    input  wire portConfig        wrCfg,
    input  wire portConfig        rdCfg,
    input  wire logic             wrLoad,
    input  wire logic             rdLoad,
    input  wire logic [CNT_W-1:0] wrCount,
    input  wire logic [CNT_W-1:0] rdCount,
    output burstReq               req,
    output logic                  reqValid,
    input  wire logic             burstDone
);

    portConfig         wrCfgR;   // Window of write port
    portConfig         rdCfgR;   // Window of read port
    logic [ADDR_W-1:0] wrAddr;
    logic [ADDR_W-1:0] rdAddr;
    logic              wrWant;
    logic              rdWant;

    // Step by length, back to start once the next burst would pass max
    function automatic logic [ADDR_W-1:0] advance(input logic [ADDR_W-1:0] addr,
                                                  input portConfig cfg);
        if (addr < cfg.maxAddr - ADDR_W'(cfg.length))
            return addr + ADDR_W'(cfg.length);
        else
            return cfg.startAddr;
    endfunction

    // Write side has a full burst waiting
    assign wrWant = (wrCount >= CNT_W'(wrCfgR.length)) && (wrCfgR.length != '0) && !wrLoad;
    // Read side running low
    assign rdWant = (rdCount < CNT_W'(rdCfgR.length)) && (rdCfgR.length != '0) && !rdLoad;

    // ====================
    // Address windows
    // ====================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            wrCfgR <= wrCfg;
            wrAddr <= wrCfg.startAddr;
        end
        else if (wrLoad)                   // Load wins over advance
        begin
            wrCfgR <= wrCfg;
            wrAddr <= wrCfg.startAddr;
        end
        else if (burstDone && req.isWrite)
            wrAddr <= advance(wrAddr, wrCfgR);
    end

    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            rdCfgR <= rdCfg;
            rdAddr <= rdCfg.startAddr;
        end
        else if (rdLoad)
        begin
            rdCfgR <= rdCfg;
            rdAddr <= rdCfg.startAddr;
        end
        else if (burstDone && !req.isWrite)
            rdAddr <= advance(rdAddr, rdCfgR);
    end

    // ====================
    // Request
    // ====================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
            reqValid <= 1'b0;
        else if (reqValid)
        begin
            if (burstDone)
                reqValid <= 1'b0;          // Idle again next cycle
        end
        else if (wrWant || rdWant)
            reqValid <= 1'b1;
    end

    // Payload follows the choice while idle, frozen while valid
    always_ff @(posedge CLK)
    begin
        if (!reqValid)
        begin
            if (wrWant)
                req <= '{isWrite: 1'b1, addr: wrAddr, length: wrCfgR.length};
            else
                req <= '{isWrite: 1'b0, addr: rdAddr, length: rdCfgR.length};
        end
    end

endmodule

`default_nettype wire

// File: logic/burstSequencer.sv
/* SDRAM init, auto-refresh and page-mode burst FSM driving the
   registered command bus, write data and read FIFO strobes */
`timescale 1ns/1ps
`default_nettype none

module burstSequencer
    import sdramPkg::*;
(
    input  wire logic              CLK,
    input  wire logic              RESET_N,
    input  wire burstReq           req,
    input  wire logic              reqValid,
    output logic                   burstDone,
    output sdramBus                sdram,
    output logic [DATA_W-1:0]      dqOut,
    output logic                   dqOe,
    input  wire logic [DATA_W-1:0] wrData,
    output logic                   wrPop,
    input  wire logic [DATA_W-1:0] dqIn,
    output logic                   rdPush,
    output logic [DATA_W-1:0]      rdWord
);

    typedef enum logic [2:0] {INIT, IDLE, REF, ACT, BURST, STOP, CLOSE, PRE} seqPhase;

    seqPhase             phase;
    logic [WAIT_W-1:0]   cnt;          // Wait countdown
    logic [LEN_W-1:0]    beat;
    logic                initDone;
    logic                initRef;      // First init refresh issued
    burstReq             cur;          // Accepted burst
    logic [2:0]          cmd;
    logic [BANK_W-1:0]   busBa;
    logic [ROW_W-1:0]    busAddr;
    logic [DATA_W/8-1:0] busDqm;
    logic [REF_W-1:0]    refTimer;
    logic                refPending;
    logic                refAck;
    logic                accept;
    logic [CAS_LAT+1:0]  rdPipe;       // Read beat delayed to rdWord

    // Address fields
    logic [BANK_W-1:0] reqBank;
    logic [ROW_W-1:0]  reqRow;
    logic [COL_W-1:0]  curCol;

    assign reqBank = req.addr[COL_W+ROW_W +: BANK_W];
    assign reqRow  = req.addr[COL_W +: ROW_W];
    assign curCol  = cur.addr[COL_W-1:0];

    assign refAck = (phase == IDLE) && refPending;          // Refresh beats a request
    assign accept = (phase == IDLE) && !refPending && reqValid && !burstDone;

    // Bus straight from registers
    assign sdram = '{cke: 1'b1, csN: 1'b0, rasN: cmd[2], casN: cmd[1], weN: cmd[0],
                     ba: busBa, addr: busAddr, dqm: busDqm};
    assign wrPop  = (phase == BURST) && cur.isWrite;        // Head lands with WRITE beat
    assign dqOut  = wrData;
    assign rdPush = rdPipe[CAS_LAT+1];

    // ====================
    // Command FSM
    // ====================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            phase     <= INIT;
            cnt       <= WAIT_W'(INIT_WAIT - 1);
            beat      <= '0;
            initDone  <= 1'b0;
            initRef   <= 1'b0;
            cmd       <= CMD_NOP;
            busBa     <= '0;
            busAddr   <= '0;
            busDqm    <= '1;
            dqOe      <= 1'b0;
            burstDone <= 1'b0;
        end
        else
        begin
            cmd       <= CMD_NOP;       // One-cycle commands
            busDqm    <= '1;
            dqOe      <= 1'b0;
            burstDone <= 1'b0;
            case (phase)
                INIT:
                    if (cnt == '0)
                        phase <= CLOSE;     // Precharge all
                    else
                        cnt <= cnt - 1'b1;
                IDLE:
                    if (refAck)
                    begin
                        cmd   <= CMD_REFRESH;
                        cnt   <= WAIT_W'(T_RFC - 1);
                        phase <= REF;
                    end
                    else if (accept)
                    begin
                        cmd     <= CMD_ACTIVE;
                        busBa   <= reqBank;
                        busAddr <= reqRow;
                        cnt     <= WAIT_W'(T_RCD - 2);
                        phase   <= ACT;
                    end
                ACT:
                    if (cnt == '0)
                    begin
                        beat  <= '0;
                        phase <= BURST;
                    end
                    else
                        cnt <= cnt - 1'b1;
                BURST:
                begin
                    if (beat == '0)
                    begin
                        cmd     <= cur.isWrite ? CMD_WRITE : CMD_READ;
                        busAddr <= ROW_W'(curCol);  // A10 low, no auto precharge
                    end
                    busDqm <= '0;
                    dqOe   <= cur.isWrite;
                    beat   <= beat + 1'b1;
                    if (beat == cur.length - 1'b1)
                        phase <= STOP;
                end
                STOP:
                begin
                    cmd   <= CMD_BSTOP;             // Ends full-page burst
                    phase <= CLOSE;
                end
                CLOSE:
                begin
                    cmd     <= CMD_PRECHARGE;
                    busAddr <= initDone ? '0 : PRE_ALL;
                    cnt     <= WAIT_W'(T_RP - 1);
                    phase   <= PRE;
                end
                PRE:
                    if (cnt != '0)
                        cnt <= cnt - 1'b1;
                    else if (initDone)
                    begin
                        burstDone <= 1'b1;
                        phase     <= IDLE;
                    end
                    else
                    begin
                        cmd   <= CMD_REFRESH;       // First init refresh
                        cnt   <= WAIT_W'(T_RFC - 1);
                        phase <= REF;
                    end
                REF:
                    if (cnt != '0)
                        cnt <= cnt - 1'b1;
                    else if (initDone)
                        phase <= IDLE;
                    else if (!initRef)
                    begin
                        cmd     <= CMD_REFRESH;
                        cnt     <= WAIT_W'(T_RFC - 1);
                        initRef <= 1'b1;
                    end
                    else
                    begin
                        cmd      <= CMD_MODE;
                        busBa    <= '0;
                        busAddr  <= MODE_WORD;
                        cnt      <= WAIT_W'(T_RP - 1);  // Mode-set gap
                        initDone <= 1'b1;
                    end
                default:
                    phase <= IDLE;
            endcase
        end
    end

    // Accepted burst and captured read data
    always_ff @(posedge CLK)
    begin
        if (accept)
            cur <= req;
        rdWord <= dqIn;
    end

    // Read beats reach rdWord CAS_LAT + 2 cycles after issue
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
            rdPipe <= '0;
        else
            rdPipe <= {rdPipe[CAS_LAT:0], (phase == BURST) && !cur.isWrite};
    end

    // ====================
    // Refresh interval
    // ====================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            refTimer   <= '0;
            refPending <= 1'b0;
        end
        else
        begin
            if (refTimer == REF_W'(REF_PERIOD - 1))
            begin
                refTimer   <= '0;
                refPending <= 1'b1;     // Held until served
            end
            else
            begin
                refTimer <= refTimer + 1'b1;
                if (refAck)
                    refPending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/sdramController.sv
/* Frame-buffer controller top with write and read FIFOs,
   port arbiter and burst sequencer */
`timescale 1ns/1ps
`default_nettype none

module sdramController
    import sdramPkg::*;
(
    input  wire logic              CLK,
    input  wire logic              RESET_N,
    // Write port
    input  wire logic [DATA_W-1:0] wrData,
    input  wire logic              wrPush,
    input  wire logic              wrLoad,
    input  wire portConfig         wrCfg,
    output logic [CNT_W-1:0]       wrCount,
    // Read port
    input  wire logic              rdPop,
    input  wire logic              rdLoad,
    input  wire portConfig         rdCfg,
    output logic [DATA_W-1:0]      rdData,
    output logic [CNT_W-1:0]       rdCount,
    // SDRAM side
    output sdramBus                sdram,
    output logic [DATA_W-1:0]      dqOut,
    output logic                   dqOe,
    input  wire logic [DATA_W-1:0] dqIn
);

    burstReq           req;
    logic              reqValid;
    logic              burstDone;
    logic [DATA_W-1:0] wrHead;     // Write FIFO head to DQ
    logic              wrPop;
    logic              rdPush;
    logic [DATA_W-1:0] rdWord;     // Captured DQ to read FIFO

    sdramFifo wrFifo (.CLK(CLK), .RESET_N(RESET_N), .clear(wrLoad), .push(wrPush),
                      .pushData(wrData), .pop(wrPop), .popData(wrHead), .used(wrCount));

    sdramFifo rdFifo (.CLK(CLK), .RESET_N(RESET_N), .clear(rdLoad), .push(rdPush),
                      .pushData(rdWord), .pop(rdPop), .popData(rdData), .used(rdCount));

    portArbiter arbiter (.CLK(CLK), .RESET_N(RESET_N), .wrCfg(wrCfg), .rdCfg(rdCfg),
                         .wrLoad(wrLoad), .rdLoad(rdLoad), .wrCount(wrCount),
                         .rdCount(rdCount), .req(req), .reqValid(reqValid),
                         .burstDone(burstDone));

    burstSequencer sequencer (.CLK(CLK), .RESET_N(RESET_N), .req(req), .reqValid(reqValid),
                              .burstDone(burstDone), .sdram(sdram), .dqOut(dqOut),
                              .dqOe(dqOe), .wrData(wrHead), .wrPop(wrPop), .dqIn(dqIn),
                              .rdPush(rdPush), .rdWord(rdWord));

endmodule

`default_nettype wire

// File: testbench/sdramModel.sv
/* Behavioural SDRAM with sparse storage, per-bank open row,
   write beats on dqOe and read data after CAS latency */
`timescale 1ns/1ps
`default_nettype none

module sdramModel
    import sdramPkg::*;
(
    input  wire logic              CLK,
    input  wire sdramBus           sdram,
    input  wire logic [DATA_W-1:0] dqOut,
    input  wire logic              dqOe,
    output logic [DATA_W-1:0]      dqIn
);

    logic [DATA_W-1:0] mem [int];            // Sparse cell store
    logic [ROW_W-1:0]  openRow [1 << BANK_W];
    logic [2:0]        cmd;
    logic [BANK_W-1:0] wrBank;
    logic [COL_W-1:0]  wrCol;
    logic [BANK_W-1:0] rdBank;
    logic [COL_W-1:0]  rdCol;
    int                rdLeft = 0;           // Beats still to drive

    assign cmd = {sdram.rasN, sdram.casN, sdram.weN};

    function automatic int cellIndex(input logic [BANK_W-1:0] bank,
                                     input logic [ROW_W-1:0] row,
                                     input logic [COL_W-1:0] col);
        return int'({bank, row, col});
    endfunction

    // Unwritten cells read as zero
    function automatic logic [DATA_W-1:0] readCell(input int idx);
        if (mem.exists(idx))
            return mem[idx];
        else
            return '0;
    endfunction

    // ====================
    // Command decode
    // ====================
    always @(posedge CLK)
    begin
        // READ seen at T gives beat k on dqIn for sample T+CAS_LAT+k
        if (rdLeft > 0)
        begin
            dqIn   <= readCell(cellIndex(rdBank, openRow[rdBank], rdCol));
            rdCol  <= rdCol + 1'b1;
            rdLeft <= rdLeft - 1;
        end
        else
            dqIn <= '0;

        if (!sdram.csN)
        begin
            case (cmd)
                CMD_ACTIVE:
                    openRow[sdram.ba] <= sdram.addr;
                CMD_READ:
                begin
                    rdBank <= sdram.ba;
                    rdCol  <= sdram.addr[COL_W-1:0];
                    rdLeft <= 1 << COL_W;        // Full page until the next READ
                end
                CMD_WRITE:
                begin
                    wrBank = sdram.ba;
                    mem[cellIndex(wrBank, openRow[wrBank], sdram.addr[COL_W-1:0])] = dqOut;
                    wrCol = sdram.addr[COL_W-1:0] + 1'b1;
                end
                default:
                    if (dqOe && sdram.dqm == '0)     // Later write beats
                    begin
                        mem[cellIndex(wrBank, openRow[wrBank], wrCol)] = dqOut;
                        wrCol = wrCol + 1'b1;
                    end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: testbench/sdramController_chk.sv
/* Bound assertions on the SDRAM command bus, refresh spacing and read port */
`timescale 1ns/1ps
`default_nettype none

module sdramController_chk
    import sdramPkg::*;
(
    input wire logic             CLK,
    input wire logic             RESET_N,
    input wire sdramBus          sdram,
    input wire logic             dqOe,
    input wire logic             rdPop,
    input wire logic [CNT_W-1:0] rdCount
);

    // Full page burst plus open and close overhead
    localparam int LONGEST = T_RCD + (1 << LEN_W) + T_RP + CAS_LAT + 6;

    logic [2:0] cmd;
    int         initCnt;
    int         sinceRef;
    logic       refSeen;

    assign cmd = {sdram.rasN, sdram.casN, sdram.weN};

    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            initCnt  <= 0;
            sinceRef <= 0;
            refSeen  <= 1'b0;
        end
        else
        begin
            if (initCnt < INIT_WAIT)
                initCnt <= initCnt + 1;
            if (cmd == CMD_REFRESH)
            begin
                sinceRef <= 0;
                refSeen  <= 1'b1;
            end
            else
                sinceRef <= sinceRef + 1;
        end
    end

    initWaitNop: assert property (@(posedge CLK) disable iff (!RESET_N)
        (initCnt < INIT_WAIT) |-> (cmd == CMD_NOP))
        else $error("Command issued during power-up wait");

    refreshSpacing: assert property (@(posedge CLK) disable iff (!RESET_N)
        refSeen |-> (sinceRef <= REF_PERIOD + LONGEST))
        else $error("Refresh interval exceeded");

    dqOeOnWrite: assert property (@(posedge CLK) disable iff (!RESET_N)
        dqOe |-> ((sdram.dqm == '0) && (cmd == CMD_WRITE || cmd == CMD_NOP)))
        else $error("dqOe outside a write beat");

    popNotEmpty: assert property (@(posedge CLK) disable iff (!RESET_N)
        rdPop |-> (rdCount != '0))
        else $error("rdPop with empty read FIFO");

endmodule

`default_nettype wire

// File: testbench/sdramController_tb.sv
/* Testbench for the frame-buffer controller with SDRAM model,
   reference function, compare tasks, timeout and summary */
`timescale 1ns/1ps
`default_nettype none

module sdramController_tb
    import sdramPkg::*;
();

    localparam portConfig CFG = '{startAddr: ADDR_W'(0), maxAddr: ADDR_W'(64),
                                  length: LEN_W'(8)};
    localparam int LEN       = 8;
    localparam int PUSHES    = 72;                 // 64 + 5 + 3
    localparam int POPS      = 64 + 64 + 64 + 36;  // Tests 2 to 5
    localparam int BURST_CYC = 1 + T_RCD + LEN + 3 + T_RP + CAS_LAT + 2;
    localparam int REF_CYC   = T_RFC + 2;
    localparam int BURSTS    = (PUSHES + POPS) / LEN + 8;   // Plus reload refetches
    localparam int IDLE_CYC  = 5 * REF_PERIOD + 50 + 3 * 40 + 20;
    localparam int LIMIT     = INIT_WAIT + PUSHES + POPS + IDLE_CYC
                               + BURSTS * 2 * (BURST_CYC + REF_CYC);

    logic              CLK;
    logic              RESET_N;
    logic [DATA_W-1:0] wrData;
    logic              wrPush;
    logic              wrLoad;
    portConfig         wrCfg;
    logic [CNT_W-1:0]  wrCount;
    logic              rdPop;
    logic              rdLoad;
    portConfig         rdCfg;
    logic [DATA_W-1:0] rdData;
    logic [CNT_W-1:0]  rdCount;
    sdramBus           sdram;
    logic [DATA_W-1:0] dqOut;
    logic              dqOe;
    logic [DATA_W-1:0] dqIn;

    int                seed = 87227;
    logic [DATA_W-1:0] pushed [$];      // Every word handed to the write port
    string             curTest;
    int                readIdx = 0;     // Index of the next popped word
    logic              popPrev = 1'b0;
    int                checks = 0;
    int                errors = 0;
    int                testErrStart;
    int                tests = 0;
    int                cycles = 0;
    int                drainWait;       // Cycles spent waiting for a write burst

    sdramController DUT (.CLK(CLK), .RESET_N(RESET_N), .wrData(wrData), .wrPush(wrPush),
                         .wrLoad(wrLoad), .wrCfg(wrCfg), .wrCount(wrCount), .rdPop(rdPop),
                         .rdLoad(rdLoad), .rdCfg(rdCfg), .rdData(rdData), .rdCount(rdCount),
                         .sdram(sdram), .dqOut(dqOut), .dqOe(dqOe), .dqIn(dqIn));

    sdramModel memory (.CLK(CLK), .sdram(sdram), .dqOut(dqOut), .dqOe(dqOe), .dqIn(dqIn));

    bind sdramController sdramController_chk chk (.CLK(CLK), .RESET_N(RESET_N),
        .sdram(sdram), .dqOe(dqOe), .rdPop(rdPop), .rdCount(rdCount));

    // ====================
    // Reference model
    // ====================
    // Words in one window are the addresses visited before wrap times length
    function automatic int windowSize(input portConfig cfg);
        int addr;
        int n;
        addr = int'(cfg.startAddr);
        n    = 0;
        do
        begin
            n++;
            if (addr < int'(cfg.maxAddr) - int'(cfg.length))
                addr = addr + int'(cfg.length);
            else
                addr = int'(cfg.startAddr);
        end
        while (addr != int'(cfg.startAddr) && n < 100000);
        return n * int'(cfg.length);
    endfunction

    function automatic logic [DATA_W-1:0] expWord(input int k);
        return pushed[k % windowSize(CFG)];
    endfunction

    // ====================
    // Compare tasks
    // ====================
    task automatic checkWord(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkCount(input string name, input logic [CNT_W-1:0] expected,
                              input logic [CNT_W-1:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkBus(input string name, input sdramBus expected,
                            input sdramBus actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Popped word lands on rdData one cycle later and is compared at the falling edge
    always @(posedge CLK)
        popPrev <= rdPop;

    always @(negedge CLK)
    begin
        if (popPrev)
        begin
            checkWord(curTest, expWord(readIdx), rdData);
            readIdx = readIdx + 1;
        end
    end

    // ====================
    // Clock, timeout
    // ====================
    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles >= LIMIT)
        begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ====================
    // Stimulus helpers
    // ====================
    task automatic startTest(input string name);
        curTest      = name;
        testErrStart = errors;
    endtask

    task automatic endTest();
        tests++;
        $display("Test %s finished with %0d errors", curTest, errors - testErrStart);
    endtask

    // All helpers enter and leave 1 ns after a rising edge
    task automatic pushWord();
        logic [DATA_W-1:0] word;
        word   = DATA_W'($random(seed));
        wrData = word;
        wrPush = 1'b1;
        pushed.push_back(word);
        @(posedge CLK);
        #1;
        wrPush = 1'b0;
    endtask

    task automatic popWords(input int n);
        repeat (n)
        begin
            while (rdCount == '0)
            begin
                @(posedge CLK);
                #1;
            end
            rdPop = 1'b1;
            @(posedge CLK);
            #1;
            rdPop = 1'b0;
        end
    endtask

    // Held long enough for an in-flight read burst to drain into the clear
    task automatic reloadRead(input string name);
        rdLoad = 1'b1;
        @(posedge CLK);
        #1;
        readIdx = 0;
        checkCount(name, '0, rdCount);
        repeat (39) @(posedge CLK);
        #1;
        rdLoad = 1'b0;
    endtask

    // ====================
    // Test sequence
    // ====================
    initial
    begin
        RESET_N = 1'b0;
        wrData  = '0;
        wrPush  = 1'b0;
        wrLoad  = 1'b0;
        wrCfg   = CFG;
        rdPop   = 1'b0;
        rdLoad  = 1'b1;     // Read port parked until data is written
        rdCfg   = CFG;
        repeat (5) @(posedge CLK);
        #1;
        RESET_N = 1'b1;

        startTest("reset state");
        checkBus(curTest, sdramBus'{cke: 1'b1, csN: 1'b0, rasN: 1'b1, casN: 1'b1,
                                    weN: 1'b1, ba: '0, addr: '0, dqm: '1}, sdram);
        checkFlag(curTest, 1'b0, dqOe);
        checkCount(curTest, '0, rdCount);
        endTest();

        startTest("write then read");
        repeat (64) pushWord();
        while (wrCount >= CNT_W'(LEN))
        begin
            @(posedge CLK);
            #1;
        end
        rdLoad = 1'b0;
        popWords(64);
        @(posedge CLK);
        #1;
        endTest();

        startTest("window wrap");
        popWords(64);
        @(posedge CLK);
        #1;
        endTest();

        startTest("refresh preserves data");
        repeat (5 * REF_PERIOD) @(posedge CLK);
        #1;
        reloadRead(curTest);
        popWords(64);
        @(posedge CLK);
        #1;
        endTest();

        startTest("load restarts read");
        reloadRead(curTest);
        popWords(20);
        @(posedge CLK);
        #1;
        reloadRead(curTest);
        popWords(16);
        @(posedge CLK);
        #1;
        endTest();

        startTest("burst threshold");
        repeat (5) pushWord();
        repeat (50)
        begin
            @(posedge CLK);
            #1;
            checkCount(curTest, CNT_W'(5), wrCount);
        end
        repeat (3) pushWord();
        drainWait = 0;
        while (wrCount != '0 && drainWait < 2 * (BURST_CYC + REF_CYC))
        begin
            @(posedge CLK);
            #1;
            drainWait++;
        end
        checkCount(curTest, '0, wrCount);
        endTest();

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sdramController.f
logic/sdramPkg.sv
logic/sdramFifo.sv
logic/portArbiter.sv
logic/burstSequencer.sv
logic/sdramController.sv
testbench/sdramModel.sv
testbench/sdramController_chk.sv
testbench/sdramController_tb.sv

// File: build.sh
#!/usr/bin/env bash
# Compile the SDRAM controller testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module sdramController_tb \
    -f sdramController.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/simv | tee "$LOG"
runStatus=${PIPESTATUS[0]}
if [ "$runStatus" -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
